/* l1_cache.sv */
// top of the two-way write-back l1 data cache, cpu on one side and lower memory on the other
`timescale 1ns/10ps
`default_nettype none

module l1_cache #(
    parameter int  INDEX_W = 12,
    localparam int TAG_W   = l1_cache_pkg::ADDR_W - INDEX_W - l1_cache_pkg::OFFSET_W
) (
    input  wire logic                   sys_clk,
    input  wire logic                   RST,
    input  wire l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_res_t      cpu_res,
    output l1_cache_pkg::mem_req_t      mem_req,
    input  wire l1_cache_pkg::mem_res_t mem_res
);

    logic [INDEX_W-1:0]          rd_index;     // both stores follow the cpu address
    // tag store
    logic [1:0][TAG_W-1:0]       way_tag;
    logic [1:0]                  way_valid;
    logic [1:0]                  way_dirty;
    logic                        lru;
    logic                        tag_we;
    logic                        tag_way;
    logic [TAG_W-1:0]            tag_new;
    logic                        dirty_new;
    logic                        lru_we;
    logic                        lru_new;
    // data store
    l1_cache_pkg::line_t [1:0]   way_line;
    logic                        fill_we;
    logic                        fill_way;
    l1_cache_pkg::line_t         fill_line;
    logic                        word_we;
    logic                        word_way;
    l1_cache_pkg::offset_t       word_offset;
    l1_cache_pkg::word_t         word_data;

    assign rd_index = cpu_req.addr[l1_cache_pkg::OFFSET_W +: INDEX_W];

    l1_cache_ctrl #(.INDEX_W(INDEX_W)) ctrl_i (
        .sys_clk, .RST, .cpu_req, .cpu_res, .mem_req, .mem_res,
        .way_tag, .way_valid, .way_dirty, .lru,
        .tag_we, .tag_way, .tag_new, .dirty_new, .lru_we, .lru_new,
        .way_line, .fill_we, .fill_way, .fill_line,
        .word_we, .word_way, .word_offset, .word_data
    );

    l1_tag_store #(.INDEX_W(INDEX_W)) tag_store_i (
        .sys_clk, .RST, .rd_index,
        .way_tag, .way_valid, .way_dirty, .lru,
        .tag_we, .tag_way, .tag_new, .dirty_new, .lru_we, .lru_new
    );

    l1_data_store #(.INDEX_W(INDEX_W)) data_store_i (
        .sys_clk, .rd_index, .way_line,
        .fill_we, .fill_way, .fill_line,
        .word_we, .word_way, .word_offset, .word_data
    );

endmodule

`default_nettype wire

/* l1_cache_ctrl.sv */
// controller of the l1 cache, checks tags, answers the cpu and runs fills and write-backs
`timescale 1ns/10ps
`default_nettype none

module l1_cache_ctrl #(
    parameter int  INDEX_W = 12,
    localparam int TAG_W   = l1_cache_pkg::ADDR_W - INDEX_W - l1_cache_pkg::OFFSET_W
) (
    input  wire logic                   sys_clk,
    input  wire logic                   RST,
    input  wire l1_cache_pkg::cpu_req_t cpu_req,
    output l1_cache_pkg::cpu_res_t      cpu_res,
    output l1_cache_pkg::mem_req_t      mem_req,
    input  wire l1_cache_pkg::mem_res_t mem_res,
    // tag store
    input  wire logic [1:0][TAG_W-1:0]  way_tag,
    input  wire logic [1:0]             way_valid,
    input  wire logic [1:0]             way_dirty,
    input  wire logic                   lru,
    output logic                        tag_we,
    output logic                        tag_way,
    output logic [TAG_W-1:0]            tag_new,
    output logic                        dirty_new,
    output logic                        lru_we,
    output logic                        lru_new,
    // data store
    input  wire l1_cache_pkg::line_t [1:0] way_line,
    output logic                        fill_we,
    output logic                        fill_way,
    output l1_cache_pkg::line_t         fill_line,
    output logic                        word_we,
    output logic                        word_way,
    output l1_cache_pkg::offset_t       word_offset,
    output l1_cache_pkg::word_t         word_data
);

    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef enum logic [2:0] {
        idle,
        compare_tag,
        allocate,        // waiting for the line read
        allocate_wait,   // lets the filled line reach the read registers
        write_back       // read request right after the victim write
    } cache_state_t;

    cache_state_t          state_q, state_d;
    tag_t                  cpu_tag;
    index_t                cpu_index;
    l1_cache_pkg::offset_t cpu_offset;
    logic [1:0]            way_hit;
    logic                  hit;
    logic                  hit_way;
    logic                  victim;         // way picked on a miss
    logic                  victim_q;       // held until the fill
    logic                  victim_dirty;
    l1_cache_pkg::addr_t   line_addr;      // requested line
    l1_cache_pkg::addr_t   victim_addr;    // line being evicted

    //////////////////////////////
    // address split and hit logic
    //////////////////////////////

    assign cpu_tag    = cpu_req.addr[l1_cache_pkg::ADDR_W-1 -: TAG_W];
    assign cpu_index  = cpu_req.addr[l1_cache_pkg::OFFSET_W +: INDEX_W];
    assign cpu_offset = cpu_req.addr[l1_cache_pkg::OFFSET_W-1:0];

    assign way_hit[0] = way_valid[0] && (way_tag[0] == cpu_tag);
    assign way_hit[1] = way_valid[1] && (way_tag[1] == cpu_tag);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];      // both ways never hold the same tag

    // empty ways first, then the lru way
    assign victim       = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lru);
    assign victim_dirty = way_valid[victim] && way_dirty[victim];

    assign line_addr   = {cpu_req.addr[l1_cache_pkg::ADDR_W-1:l1_cache_pkg::OFFSET_W],
                          {l1_cache_pkg::OFFSET_W{1'b0}}};
    assign victim_addr = {way_tag[victim], cpu_index, {l1_cache_pkg::OFFSET_W{1'b0}}};

    //////////////////////////////
    // store write data
    //////////////////////////////

    assign tag_way     = hit ? hit_way : victim;
    assign tag_new     = cpu_tag;
    assign dirty_new   = hit;            // write hit sets dirty, a new line starts clean
    assign lru_new     = ~hit_way;       // point at the way not just used
    assign word_way    = hit_way;
    assign word_offset = cpu_offset;
    assign word_data   = cpu_req.data;
    assign fill_way    = victim_q;
    assign fill_line   = mem_res.data;

    //////////////////////////////
    // fsm
    //////////////////////////////

    always_comb
    begin
        state_d       = state_q;
        cpu_res.ready = 1'b0;
        cpu_res.data  = way_line[hit_way][int'(cpu_offset)*l1_cache_pkg::WORD_W +:
                                          l1_cache_pkg::WORD_W];
        mem_req.addr  = line_addr;
        mem_req.data  = way_line[victim];
        mem_req.rw    = 1'b0;
        mem_req.valid = 1'b0;
        tag_we        = 1'b0;
        lru_we        = 1'b0;
        fill_we       = 1'b0;
        word_we       = 1'b0;

        case (state_q)
            idle:
            begin
                if (cpu_req.valid)
                begin
                    state_d = compare_tag;   // stores read this address at the edge
                end
            end

            compare_tag:
            begin
                if (hit)
                begin
                    cpu_res.ready = 1'b1;
                    lru_we        = 1'b1;
                    if (cpu_req.rw)
                    begin
                        word_we = 1'b1;      // merge the word
                        tag_we  = 1'b1;      // and mark the line dirty
                    end
                    state_d = idle;
                end
                else
                begin
                    tag_we        = 1'b1;    // victim takes the new tag, clean
                    mem_req.valid = 1'b1;
                    if (victim_dirty)
                    begin
                        mem_req.addr = victim_addr;
                        mem_req.rw   = 1'b1;
                        state_d      = write_back;
                    end
                    else
                    begin
                        state_d = allocate;  // line read goes out now
                    end
                end
            end

            write_back:
            begin
                mem_req.valid = 1'b1;        // line read after the victim write
                state_d       = allocate;
            end

            allocate:
            begin
                if (mem_res.ready)
                begin
                    fill_we = 1'b1;
                    state_d = allocate_wait;
                end
            end

            allocate_wait:
            begin
                state_d = compare_tag;       // retry, now a hit
            end

            default:
            begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge sys_clk)
    begin
        if (RST)
        begin
            state_q  <= idle;
            victim_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == compare_tag && !hit)
            begin
                victim_q <= victim;
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // a line read is never followed by another request
    a_read_alone : assert property (@(posedge sys_clk) disable iff (RST)
        mem_req.valid && !mem_req.rw |=> !mem_req.valid);

    // every write-back is chained straight to its line read
    a_write_then_read : assert property (@(posedge sys_clk) disable iff (RST)
        mem_req.valid && mem_req.rw |=> mem_req.valid && !mem_req.rw);

    a_ready_in_compare : assert property (@(posedge sys_clk) disable iff (RST)
        cpu_res.ready |-> state_q == compare_tag);

endmodule

`default_nettype wire

/* l1_cache_pkg.sv */
// shared widths, vector types and bus structs of the l1 data cache, referenced by scoped name
`default_nettype none

package l1_cache_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int ADDR_W         = 27;     // cpu word address
    localparam int WORD_W         = 32;     // one data word
    localparam int OFFSET_W       = 2;      // word position in a line
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = 128;    // WORDS_PER_LINE * WORD_W

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;    // word 0 sits in the low bits
    typedef logic [OFFSET_W-1:0] offset_t;

    //////////////////////////////
    // bus structs
    //////////////////////////////

    // cpu -> cache, held until ready
    typedef struct packed {
        addr_t addr;
        word_t data;    // write data
        logic  rw;      // 1 = write
        logic  valid;
    } cpu_req_t;

    // cache -> cpu
    typedef struct packed {
        word_t data;    // read data, only meaningful on reads
        logic  ready;   // one-cycle pulse
    } cpu_res_t;

    // cache -> lower memory, always one line
    typedef struct packed {
        addr_t addr;    // line aligned, offset bits zero
        line_t data;    // write-back line
        logic  rw;      // 1 = write
        logic  valid;   // one-cycle pulse
    } mem_req_t;

    // lower memory -> cache, answers a line read
    typedef struct packed {
        line_t data;
        logic  ready;   // one-cycle pulse
    } mem_res_t;

endpackage

`default_nettype wire

/* l1_data_store.sv */
// line store of the two-way l1 cache, filled a line at a time and written a word at a time
`timescale 1ns/10ps
`default_nettype none

module l1_data_store #(
    parameter int INDEX_W = 12
) (
    input  wire logic                   sys_clk,
    input  wire logic [INDEX_W-1:0]     rd_index,
    output l1_cache_pkg::line_t [1:0]   way_line,     // registered read, both ways
    input  wire logic                   fill_we,      // whole line from memory
    input  wire logic                   fill_way,
    input  wire l1_cache_pkg::line_t    fill_line,
    input  wire logic                   word_we,      // single word on a write hit
    input  wire logic                   word_way,
    input  wire l1_cache_pkg::offset_t  word_offset,
    input  wire l1_cache_pkg::word_t    word_data
);

    localparam int SETS = 2 ** INDEX_W;

    // kept as words so a write hit touches one word only
    l1_cache_pkg::word_t line_mem [2][SETS][l1_cache_pkg::WORDS_PER_LINE];

    //////////////////////////////
    // write and registered read
    //////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        for (int w = 0; w < 2; w++)
        begin
            for (int k = 0; k < l1_cache_pkg::WORDS_PER_LINE; k++)
            begin
                if (fill_we && fill_way == 1'(w))
                begin
                    // fill overwrites all four words
                    line_mem[w][rd_index][k] <=
                        fill_line[k*l1_cache_pkg::WORD_W +: l1_cache_pkg::WORD_W];
                end
                else if (word_we && word_way == 1'(w) &&
                         word_offset == l1_cache_pkg::offset_t'(k))
                begin
                    line_mem[w][rd_index][k] <= word_data;   // merge one word
                end
                way_line[w][k*l1_cache_pkg::WORD_W +: l1_cache_pkg::WORD_W] <=
                    line_mem[w][rd_index][k];                // old data on a write edge
            end
        end
    end

    // controller never fills and merges in the same cycle
    a_one_writer : assert property (@(posedge sys_clk)
        !(fill_we && word_we));

endmodule

`default_nettype wire

/* l1_tag_store.sv */
// tag store of the two-way l1 cache, read one cycle after the index and written by the controller
`timescale 1ns/10ps
`default_nettype none

module l1_tag_store #(
    parameter int  INDEX_W = 12,
    localparam int TAG_W   = l1_cache_pkg::ADDR_W - INDEX_W - l1_cache_pkg::OFFSET_W
) (
    input  wire logic                sys_clk,
    input  wire logic                RST,
    input  wire logic [INDEX_W-1:0]  rd_index,   // set of the current cpu address
    output logic [1:0][TAG_W-1:0]    way_tag,
    output logic [1:0]               way_valid,
    output logic [1:0]               way_dirty,
    output logic                     lru,        // way to replace next
    input  wire logic                tag_we,
    input  wire logic                tag_way,
    input  wire logic [TAG_W-1:0]    tag_new,
    input  wire logic                dirty_new,
    input  wire logic                lru_we,
    input  wire logic                lru_new
);

    localparam int SETS = 2 ** INDEX_W;

    typedef logic [TAG_W-1:0] tag_t;

    // one entry per way and set
    typedef struct packed {
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    tag_entry_t            entry_mem [2][SETS];  // plain ram, no reset
    logic [1:0][SETS-1:0]  valid_q;              // flops, cleared by RST
    logic [SETS-1:0]       lru_q;                // replacement bit per set

    //////////////////////////////
    // tag and dirty ram
    //////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        for (int w = 0; w < 2; w++)
        begin
            if (tag_we && tag_way == 1'(w))
            begin
                entry_mem[w][rd_index] <= '{dirty: dirty_new, tag: tag_new};
            end
            way_tag[w]   <= entry_mem[w][rd_index].tag;    // read before write
            way_dirty[w] <= entry_mem[w][rd_index].dirty;
        end
    end

    //////////////////////////////
    // valid and lru flops
    //////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        if (RST)
        begin
            valid_q   <= '0;    // cold cache
            lru_q     <= '0;
            way_valid <= '0;
            lru       <= 1'b0;
        end
        else
        begin
            if (tag_we)
            begin
                valid_q[tag_way][rd_index] <= 1'b1;  // any tag write makes the way valid
            end
            if (lru_we)
            begin
                lru_q[rd_index] <= lru_new;
            end
            way_valid <= {valid_q[1][rd_index], valid_q[0][rd_index]};
            lru       <= lru_q[rd_index];
        end
    end

    a_tag_we_known : assert property (@(posedge sys_clk) disable iff (RST)
        !$isunknown(tag_we));

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds the l1 cache testbench with verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    -f src.f \
    --top-module tb_l1_cache \
    -Mdir obj_dir \
    -o sim_l1_cache

# the run itself may stop with a nonzero code, the log decides
./obj_dir/sim_l1_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log
then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

/* src.f */
l1_cache_pkg.sv
l1_tag_store.sv
l1_data_store.sv
l1_cache_ctrl.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

/* tb_l1_cache.sv */
// testbench of the l1 cache, directed and random traffic checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_l1_cache;

    localparam int INDEX_W = 4;
    localparam int TAG_W   = l1_cache_pkg::ADDR_W - INDEX_W - l1_cache_pkg::OFFSET_W;
    localparam int SETS    = 2 ** INDEX_W;
    localparam int TIMEOUT = 40;        // cycles allowed per access

    logic                   sys_clk = 1'b0;
    logic                   RST     = 1'b1;
    l1_cache_pkg::cpu_req_t cpu_req = '0;
    l1_cache_pkg::cpu_res_t cpu_res;
    l1_cache_pkg::mem_req_t mem_req;
    l1_cache_pkg::mem_res_t mem_res;
    int                     wr_count;
    l1_cache_pkg::addr_t    wr_addr;
    l1_cache_pkg::line_t    wr_line;

    // reference tag store, and memory as the cpu should see it
    bit [TAG_W-1:0]         ref_tag   [2][SETS];
    bit                     ref_valid [2][SETS];
    bit                     ref_dirty [2][SETS];
    bit                     ref_lru   [SETS];
    l1_cache_pkg::word_t    ref_mem   [l1_cache_pkg::addr_t];
    int                     ref_wb_count = 0;
    logic [31:0]            rnd = 32'h67ed8522;

    always #4 sys_clk = ~sys_clk;       // 8 ns period

    l1_cache #(.INDEX_W(INDEX_W)) l1_cache_i (
        .sys_clk, .RST, .cpu_req, .cpu_res, .mem_req, .mem_res
    );

    tb_mem_model mem_i (
        .sys_clk, .RST, .mem_req, .mem_res, .wr_count, .wr_addr, .wr_line
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic l1_cache_pkg::word_t pattern_word(input l1_cache_pkg::addr_t a);
        return {5'h15, a} ^ 32'h0f0f_3c3c;   // memory contents before any write
    endfunction

    function automatic l1_cache_pkg::word_t expected_word(input l1_cache_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : pattern_word(a);
    endfunction

    function automatic l1_cache_pkg::addr_t make_addr(input logic [TAG_W-1:0] tag,
                                                      input int set, input int offset);
        return {tag, INDEX_W'(set), l1_cache_pkg::offset_t'(offset)};
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
        begin
            fail_stop($sformatf("mismatch at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic void predict(input l1_cache_pkg::addr_t a, input logic rw,
                                    input l1_cache_pkg::word_t data, output logic hit,
                                    output logic wb, output l1_cache_pkg::addr_t wb_addr,
                                    output l1_cache_pkg::line_t wb_line,
                                    output l1_cache_pkg::word_t rdata);
        logic [TAG_W-1:0] tag;
        int               set;
        int               way;
        tag     = a[l1_cache_pkg::ADDR_W-1 -: TAG_W];
        set     = int'(a[l1_cache_pkg::OFFSET_W +: INDEX_W]);
        hit     = 1'b0;
        wb      = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        way     = 0;
        for (int w = 0; w < 2; w++)
        begin
            if (ref_valid[w][set] && ref_tag[w][set] == tag)
            begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit)
        begin
            // empty way 0, then empty way 1, then the lru way
            way = !ref_valid[0][set] ? 0 : (!ref_valid[1][set] ? 1 : int'(ref_lru[set]));
            if (ref_valid[way][set] && ref_dirty[way][set])
            begin
                wb      = 1'b1;
                wb_addr = make_addr(ref_tag[way][set], set, 0);
                for (int k = 0; k < l1_cache_pkg::WORDS_PER_LINE; k++)
                begin
                    wb_line[k*l1_cache_pkg::WORD_W +: l1_cache_pkg::WORD_W] =
                        expected_word(wb_addr + l1_cache_pkg::addr_t'(k));
                end
                ref_wb_count++;
            end
            ref_tag[way][set]   = tag;
            ref_valid[way][set] = 1'b1;
            ref_dirty[way][set] = 1'b0;     // fresh line starts clean
        end
        ref_lru[set] = (way == 0);          // retried access always hits
        if (rw)
        begin
            ref_dirty[way][set] = 1'b1;
            ref_mem[a]          = data;
        end
        rdata = expected_word(a);
    endfunction

    // one cpu access, driven and sampled on falling edges
    task automatic do_access(input l1_cache_pkg::addr_t a, input logic rw,
                             input l1_cache_pkg::word_t data);
        logic                exp_hit;
        logic                exp_wb;
        l1_cache_pkg::addr_t wb_addr;
        l1_cache_pkg::line_t wb_line;
        l1_cache_pkg::word_t rdata;
        int                  cycles;
        int                  wr_before;
        predict(a, rw, data, exp_hit, exp_wb, wb_addr, wb_line, rdata);
        wr_before = wr_count;
        cpu_req   = '{addr: a, data: data, rw: rw, valid: 1'b1};
        cycles    = 0;
        while (cycles == 0 || !cpu_res.ready)
        begin
            if (cycles >= TIMEOUT)
            begin
                fail_stop($sformatf("no ready from the cache for address %0h", a));
            end
            @(negedge sys_clk);
            cycles++;
        end
        check_value("single-cycle hit", 128'(cycles == 1), 128'(exp_hit));
        if (!rw)
        begin
            check_value("cpu_res.data", 128'(cpu_res.data), 128'(rdata));
        end
        check_value("write-back pulses", 128'(wr_count - wr_before), 128'(exp_wb));
        if (exp_wb)
        begin
            check_value("write-back mem_req.addr", 128'(wr_addr), 128'(wb_addr));
            check_value("write-back mem_req.data", wr_line, wb_line);
        end
        @(negedge sys_clk);                 // request held through the accepting edge
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial
    begin
        logic [TAG_W-1:0]    t;
        l1_cache_pkg::addr_t a;
        logic                rw;
        repeat (4) @(negedge sys_clk);
        RST = 1'b0;
        @(negedge sys_clk);

        // cold read, then hits in the same line
        rnd = xorshift32(rnd);
        t   = rnd[TAG_W-1:0];
        do_access(make_addr(t, 3, 1), 1'b0, '0);
        do_access(make_addr(t, 3, 2), 1'b0, '0);
        // write hit, neighbours keep their data
        rnd = xorshift32(rnd);
        do_access(make_addr(t, 3, 1), 1'b1, rnd);
        do_access(make_addr(t, 3, 1), 1'b0, '0);
        do_access(make_addr(t, 3, 0), 1'b0, '0);
        do_access(make_addr(t, 3, 3), 1'b0, '0);

        // write miss merges into a freshly filled line
        rnd = xorshift32(rnd);
        do_access(make_addr(t, 5, 2), 1'b1, rnd);
        for (int k = 0; k < 4; k++)
        begin
            do_access(make_addr(t, 5, k), 1'b0, '0);
        end

        // three tags in set 7, dirty then clean eviction
        rnd = xorshift32(rnd);
        t   = rnd[TAG_W-1:0];
        rnd = xorshift32(rnd);
        do_access(make_addr(t, 7, 1), 1'b1, rnd);
        do_access(make_addr(t ^ TAG_W'(1), 7, 0), 1'b0, '0);
        do_access(make_addr(t ^ TAG_W'(2), 7, 3), 1'b0, '0);     // evicts the dirty line
        do_access(make_addr(t ^ TAG_W'(1), 7, 0), 1'b0, '0);
        do_access(make_addr(t, 7, 1), 1'b0, '0);                 // back through memory

        // random mix over four tags and four sets
        for (int i = 0; i < 400; i++)
        begin
            rnd = xorshift32(rnd);
            a   = make_addr(t + TAG_W'(rnd[9:8]), int'(rnd[5:4]), int'(rnd[1:0]));
            rw  = rnd[31];
            rnd = xorshift32(rnd);
            do_access(a, rw, rnd);
        end
        cpu_req.valid = 1'b0;

        check_value("write-back total", 128'(wr_count), 128'(ref_wb_count));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// lower-memory model for the l1 cache testbench, answers line reads late and counts write-backs
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter int DELAY = 3     // cycles from read request to answer
) (
    input  wire logic                   sys_clk,
    input  wire logic                   RST,
    input  wire l1_cache_pkg::mem_req_t mem_req,
    output l1_cache_pkg::mem_res_t      mem_res,
    output int                          wr_count,   // write pulses seen so far
    output l1_cache_pkg::addr_t         wr_addr,    // last write-back address
    output l1_cache_pkg::line_t         wr_line     // last write-back line
);

    l1_cache_pkg::word_t    store [l1_cache_pkg::addr_t];   // sparse, only written words
    l1_cache_pkg::mem_res_t res_q     = '0;
    int                     wr_q      = 0;
    l1_cache_pkg::addr_t    wr_addr_q = '0;
    l1_cache_pkg::line_t    wr_line_q = '0;
    int                     delay_q   = 0;      // 0 when no read is pending
    l1_cache_pkg::addr_t    rd_addr_q = '0;

    assign mem_res  = res_q;
    assign wr_count = wr_q;
    assign wr_addr  = wr_addr_q;
    assign wr_line  = wr_line_q;

    // contents of a word never written, depends on every address bit
    function automatic l1_cache_pkg::word_t pattern_word(input l1_cache_pkg::addr_t a);
        return {5'h15, a} ^ 32'h0f0f_3c3c;
    endfunction

    function automatic l1_cache_pkg::line_t read_line(input l1_cache_pkg::addr_t base);
        l1_cache_pkg::line_t line;
        l1_cache_pkg::addr_t a;
        for (int k = 0; k < l1_cache_pkg::WORDS_PER_LINE; k++)
        begin
            a = base + l1_cache_pkg::addr_t'(k);
            line[k*l1_cache_pkg::WORD_W +: l1_cache_pkg::WORD_W] =
                store.exists(a) ? store[a] : pattern_word(a);
        end
        return line;
    endfunction

    //////////////////////////////
    // request handling, falling edge
    //////////////////////////////

    always @(negedge sys_clk)
    begin
        res_q.ready <= 1'b0;                    // answer is a single pulse
        if (RST)
        begin
            delay_q <= 0;
        end
        else
        begin
            if (delay_q == 1)
            begin
                res_q.ready <= 1'b1;
                res_q.data  <= read_line(rd_addr_q);
            end
            if (delay_q != 0)
            begin
                delay_q <= delay_q - 1;
            end
            if (mem_req.valid && mem_req.rw)
            begin
                for (int k = 0; k < l1_cache_pkg::WORDS_PER_LINE; k++)
                begin
                    store[mem_req.addr + l1_cache_pkg::addr_t'(k)] =
                        mem_req.data[k*l1_cache_pkg::WORD_W +: l1_cache_pkg::WORD_W];
                end
                wr_q      <= wr_q + 1;
                wr_addr_q <= mem_req.addr;
                wr_line_q <= mem_req.data;
            end
            else if (mem_req.valid)
            begin
                rd_addr_q <= mem_req.addr;      // line read, answered DELAY cycles on
                delay_q   <= DELAY;
            end
        end
    end

endmodule

`default_nettype wire
